//--- Makefile
# Verilator build and run for the frog lane testbench
# Override any variable on the command line, e.g. make run LOG=my.log

VERILATOR ?= verilator
TOP       ?= frogger_tb
FILELIST  ?= compile.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -j 0
PASS_MSG  ?= test passed

SOURCES := $(shell cat $(FILELIST))

.PHONY: all compile run clean

all: run

compile: $(BUILD_DIR)/V$(TOP)

$(BUILD_DIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: compile
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@grep -qx "$(PASS_MSG)" $(LOG) || (echo "Simulation did not pass, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- compile.f
rtl/frogger_pkg.sv
rtl/arena_if.sv
rtl/frog_move_decode.sv
rtl/car.sv
rtl/hit_result.sv
rtl/frogger_lane_top.sv
test/frogger_tb.sv

//--- rtl/arena_if.sv
//--------------------------------------------------
// Frog and car positions shared inside the lane
// All signals come straight from registers
//--------------------------------------------------

`timescale 1ns/1ps

interface arena_if;

    frogger_pkg::coord_t frog_x;          // Frog top left column
    frogger_pkg::coord_t frog_y;          // Frog top left row
    frogger_pkg::coord_t car_x;           // Car top left column
    frogger_pkg::coord_t car_y;           // Car top left row

    // Frog position owner
    modport frog (
        output frog_x,
        output frog_y
    );

    // Car position owner
    modport car (
        output car_x,
        output car_y
    );

    // Collision and home checker
    modport judge (
        input frog_x,
        input frog_y,
        input car_x,
        input car_y
    );

endinterface

//--- rtl/car.sv
//--------------------------------------------------
// One car on a fixed lane that steps CAR_STEP pixels
// Steps once every speed+1 frames
// Wraps to the far edge and never changes row
//--------------------------------------------------

`timescale 1ns/1ps

module car #(
    parameter frogger_pkg::coord_t CAR_START_X = 11'd0,   // Column after reset
    parameter frogger_pkg::coord_t CAR_LANE_Y  = 11'd200, // Fixed row
    parameter logic                CAR_DIR     = 1'b1     // 1 rightward, 0 leftward
) (
    input  logic                reset,      // Frame clock
    input  logic                frame_clk,  // Async reset, active high
    input  frogger_pkg::speed_t speed,      // Wait frames, sampled each cycle
    arena_if.car                arena
);

    // MOVE is the frame right after a step with the count at 0
    // WAIT counts frames 1 up to speed
    typedef enum logic {
        st_move = 1'b0,
        st_wait = 1'b1
    } car_state_t;

    car_state_t          state;
    car_state_t          next_state;
    frogger_pkg::speed_t wait_cnt;        // Frames since last step
    logic                step;            // Car moves on this edge
    frogger_pkg::coord_t x_step;          // Column after one step

    // --------------------------------------------------
    // Move/wait FSM
    // --------------------------------------------------
    always_comb
    begin
        next_state = state;
        step       = 1'b0;
        case (state)
            st_move:
            begin
                if (speed == '0)
                    step = 1'b1;          // Step again without waiting
                else
                    next_state = st_wait;
            end
            st_wait:
            begin
                if (wait_cnt == speed)
                begin
                    step       = 1'b1;    // Count reached
                    next_state = st_move;
                end
            end
        endcase
    end

    // --------------------------------------------------
    // Step with screen wrap
    // --------------------------------------------------
    always_comb
    begin
        if (CAR_DIR)
        begin
            if (arena.car_x + frogger_pkg::CAR_STEP > frogger_pkg::SCREEN_W)
                x_step = '0;              // Past right edge to column 0
            else
                x_step = arena.car_x + frogger_pkg::CAR_STEP;
        end
        else
        begin
            if (arena.car_x < frogger_pkg::CAR_STEP)
                x_step = frogger_pkg::SCREEN_W; // Off left edge
            else
                x_step = arena.car_x - frogger_pkg::CAR_STEP;
        end
    end

    // --------------------------------------------------
    // State, counter and position registers
    // --------------------------------------------------
    always_ff @(posedge reset or posedge frame_clk)
    begin
        if (frame_clk)
        begin
            state       <= st_move;       // Counter starts at 0
            wait_cnt    <= '0;
            arena.car_x <= CAR_START_X;
            arena.car_y <= CAR_LANE_Y;
        end
        else
        begin
            state <= next_state;
            if (step)
            begin
                wait_cnt    <= '0;        // Restart frame count
                arena.car_x <= x_step;
            end
            else
                wait_cnt <= wait_cnt + 5'd1;  // One more waiting frame
            arena.car_y <= CAR_LANE_Y;    // Lane row never moves
        end
    end

endmodule

//--- rtl/frog_move_decode.sv
//--------------------------------------------------
// Each key strobe moves the frog one hop
// Moves clamp at the playfield edges
// Respawn beats a key in the same cycle
// Keys are dropped while game over is high
//--------------------------------------------------

`timescale 1ns/1ps

module frog_move_decode (
    input  logic              reset,      // Frame clock
    input  logic              frame_clk,  // Async reset, active high
    input  logic              key_valid,  // One-cycle key strobe
    input  frogger_pkg::key_t key_code,   // Valid with key_valid only
    input  logic              respawn,    // Back to spawn next edge
    input  logic              game_over,  // Freezes the frog
    arena_if.frog             arena
);

    // Highest legal top left corner
    localparam frogger_pkg::coord_t X_LIMIT = frogger_pkg::SCREEN_W - frogger_pkg::FROG_SIDE;
    localparam frogger_pkg::coord_t Y_LIMIT = frogger_pkg::SCREEN_H - frogger_pkg::FROG_SIDE;

    frogger_pkg::coord_t x_next;          // Position after this key
    frogger_pkg::coord_t y_next;

    // --------------------------------------------------
    // Move decode with clamp
    // --------------------------------------------------
    always_comb
    begin
        x_next = arena.frog_x;            // Hold by default
        y_next = arena.frog_y;
        if (key_valid && !game_over)
        begin
            case (key_code)
                frogger_pkg::key_up:
                begin
                    if (arena.frog_y < frogger_pkg::FROG_STEP)
                        y_next = '0;      // Stop at top row
                    else
                        y_next = arena.frog_y - frogger_pkg::FROG_STEP;
                end
                frogger_pkg::key_down:
                begin
                    if (arena.frog_y + frogger_pkg::FROG_STEP > Y_LIMIT)
                        y_next = Y_LIMIT; // Stop at bottom row
                    else
                        y_next = arena.frog_y + frogger_pkg::FROG_STEP;
                end
                frogger_pkg::key_left:
                begin
                    if (arena.frog_x < frogger_pkg::FROG_STEP)
                        x_next = '0;      // Left wall
                    else
                        x_next = arena.frog_x - frogger_pkg::FROG_STEP;
                end
                frogger_pkg::key_right:
                begin
                    if (arena.frog_x + frogger_pkg::FROG_STEP > X_LIMIT)
                        x_next = X_LIMIT; // Right wall
                    else
                        x_next = arena.frog_x + frogger_pkg::FROG_STEP;
                end
            endcase
        end
    end

    // --------------------------------------------------
    // Position registers
    // --------------------------------------------------
    always_ff @(posedge reset or posedge frame_clk)
    begin
        if (frame_clk)
        begin
            arena.frog_x <= frogger_pkg::FROG_START_X;
            arena.frog_y <= frogger_pkg::FROG_START_Y;
        end
        else if (respawn)                 // Hit or home order
        begin
            arena.frog_x <= frogger_pkg::FROG_START_X;
            arena.frog_y <= frogger_pkg::FROG_START_Y;
        end
        else
        begin
            arena.frog_x <= x_next;       // New spot seen next cycle
            arena.frog_y <= y_next;
        end
    end

endmodule

//--- rtl/frogger_lane_top.sv
//--------------------------------------------------
// One frog lane clocked once per video frame
// Car lane set by parameters with one car only
// Keys have no back-pressure
//--------------------------------------------------

`timescale 1ns/1ps

module frogger_lane_top #(
    parameter frogger_pkg::coord_t CAR_START_X = 11'd0,   // Car column after reset
    parameter frogger_pkg::coord_t CAR_LANE_Y  = 11'd200, // Car row
    parameter logic                CAR_DIR     = 1'b1     // 1 rightward
) (
    input  logic                reset,      // Frame clock
    input  logic                frame_clk,  // Async reset, active high
    input  logic                key_valid,  // One-cycle key strobe
    input  frogger_pkg::key_t   key_code,
    input  frogger_pkg::speed_t speed,      // Car wait frames
    output frogger_pkg::coord_t frog_x,
    output frogger_pkg::coord_t frog_y,
    output frogger_pkg::coord_t car_x,
    output frogger_pkg::coord_t car_y,
    output logic                hit,
    output frogger_pkg::count_t score,
    output frogger_pkg::lives_t lives,
    output logic                game_over
);

    logic respawn;                        // Result to decode strobe

    arena_if arena ();                    // Shared positions

    // --------------------------------------------------
    // Blocks
    // --------------------------------------------------
    frog_move_decode i_frog_move_decode (
        .reset     (reset),
        .frame_clk (frame_clk),
        .key_valid (key_valid),
        .key_code  (key_code),
        .respawn   (respawn),
        .game_over (game_over),
        .arena     (arena.frog)
    );

    car #(
        .CAR_START_X (CAR_START_X),
        .CAR_LANE_Y  (CAR_LANE_Y),
        .CAR_DIR     (CAR_DIR)
    ) i_car (
        .reset     (reset),
        .frame_clk (frame_clk),
        .speed     (speed),
        .arena     (arena.car)
    );

    hit_result i_hit_result (
        .reset     (reset),
        .frame_clk (frame_clk),
        .arena     (arena.judge),
        .hit       (hit),
        .respawn   (respawn),
        .score     (score),
        .lives     (lives),
        .game_over (game_over)
    );

    // Positions out to the pins
    assign frog_x = arena.frog_x;
    assign frog_y = arena.frog_y;
    assign car_x  = arena.car_x;
    assign car_y  = arena.car_y;

endmodule

//--- rtl/frogger_pkg.sv
//--------------------------------------------------
// Shared types and constants for one frog lane
// Coordinates are unsigned pixels from the top left
// Playfield is fixed at 640 by 480
//--------------------------------------------------

package frogger_pkg;

    // --------------------------------------------------
    // Types
    // --------------------------------------------------
    typedef logic [10:0] coord_t;          // Pixel coordinate
    typedef logic [4:0]  speed_t;          // Extra wait frames per car step
    typedef logic [7:0]  count_t;          // Score that wraps at 255
    typedef logic [1:0]  lives_t;          // Lives left

    typedef enum logic [1:0] {
        key_up    = 2'd0,                  // Toward row 0
        key_down  = 2'd1,                  // Toward bottom edge
        key_left  = 2'd2,
        key_right = 2'd3
    } key_t;

    // --------------------------------------------------
    // Playfield and sprites
    // --------------------------------------------------
    localparam coord_t SCREEN_W     = 11'd640;
    localparam coord_t SCREEN_H     = 11'd480;

    localparam coord_t FROG_SIDE    = 11'd40;   // Square frog sprite
    localparam coord_t FROG_STEP    = 11'd40;   // One hop per key

    localparam coord_t CAR_W        = 11'd80;
    localparam coord_t CAR_H        = 11'd40;
    localparam coord_t CAR_STEP     = 11'd10;   // Pixels per car move

    // Frog box shrink on each side for the hit test
    localparam coord_t X_TOL        = 11'd10;
    localparam coord_t Y_TOL        = 11'd1;

    localparam coord_t FROG_START_X = 11'd300;  // Spawn column
    localparam coord_t FROG_START_Y = 11'd440;  // Bottom row

    localparam lives_t START_LIVES  = 2'd3;

endpackage

//--- rtl/hit_result.sv
//--------------------------------------------------
// Frog against car plus the home row check
// Events are ignored in game over and during respawn
// Hit wins over home in the same cycle
//--------------------------------------------------

`timescale 1ns/1ps

module hit_result (
    input  logic                reset,      // Frame clock
    input  logic                frame_clk,  // Async reset, active high
    arena_if.judge              arena,
    output logic                hit,        // One-cycle hit strobe
    output logic                respawn,    // One-cycle order to frog
    output frogger_pkg::count_t score,
    output frogger_pkg::lives_t lives,
    output logic                game_over   // Sticky until reset
);

    frogger_pkg::coord_t fx_l, fx_r;      // Shrunk frog box columns
    frogger_pkg::coord_t fy_t, fy_b;      // Shrunk frog box rows
    frogger_pkg::coord_t cx_r, cy_b;      // Car far edges
    logic                in_xl, in_xr;    // Frog column inside car span
    logic                in_yt, in_yb;    // Frog row inside car span
    logic                overlap;
    logic                hit_ev;
    logic                home_ev;

    // --------------------------------------------------
    // Four-corner overlap with edges counted as a touch
    // --------------------------------------------------
    assign fx_l = arena.frog_x + frogger_pkg::X_TOL;
    assign fx_r = arena.frog_x + frogger_pkg::FROG_SIDE - frogger_pkg::X_TOL;
    assign fy_t = arena.frog_y + frogger_pkg::Y_TOL;
    assign fy_b = arena.frog_y + frogger_pkg::FROG_SIDE - frogger_pkg::Y_TOL;
    assign cx_r = arena.car_x + frogger_pkg::CAR_W;
    assign cy_b = arena.car_y + frogger_pkg::CAR_H;

    assign in_xl = (fx_l >= arena.car_x) && (fx_l <= cx_r);
    assign in_xr = (fx_r >= arena.car_x) && (fx_r <= cx_r);
    assign in_yt = (fy_t >= arena.car_y) && (fy_t <= cy_b);
    assign in_yb = (fy_b >= arena.car_y) && (fy_b <= cy_b);

    assign overlap = (in_xl && in_yt)     // Top left
                  || (in_xl && in_yb)     // Bottom left
                  || (in_xr && in_yt)     // Top right
                  || (in_xr && in_yb);    // Bottom right

    // Frog still sits on the old spot while respawn is high
    assign hit_ev  = overlap && !game_over && !respawn;
    assign home_ev = (arena.frog_y == '0) && !overlap && !game_over && !respawn;

    // --------------------------------------------------
    // Strobes and counters
    // --------------------------------------------------
    always_ff @(posedge reset or posedge frame_clk)
    begin
        if (frame_clk)
        begin
            hit       <= 1'b0;
            respawn   <= 1'b0;
            score     <= '0;
            lives     <= frogger_pkg::START_LIVES;
            game_over <= 1'b0;
        end
        else
        begin
            hit     <= hit_ev;
            respawn <= hit_ev || home_ev; // Either event sends frog home
            if (hit_ev)
            begin
                lives <= lives - 2'd1;
                if (lives == 2'd1)
                    game_over <= 1'b1;    // Last life gone
            end
            if (home_ev)
                score <= score + 8'd1;    // Wraps past 255
        end
    end

endmodule

//--- test/frogger_tb.sv
//--------------------------------------------------
// Testbench for one frog lane with default car parameters
// Car starts at column 0 in row 200 and moves right
// Every output is compared with a model each cycle
//--------------------------------------------------

`timescale 1ns/1ps

module frogger_tb;

    typedef struct packed {
        logic              kv;            // Strobe in first cycle of row
        frogger_pkg::key_t kc;
        frogger_pkg::speed_t spd;
        int                hold;          // Cycles spent on this row
    } row_t;

    localparam int SCR_W   = int'(frogger_pkg::SCREEN_W);
    localparam int SCR_H   = int'(frogger_pkg::SCREEN_H);
    localparam int FSIDE   = int'(frogger_pkg::FROG_SIDE);
    localparam int FSTEP   = int'(frogger_pkg::FROG_STEP);
    localparam int CW      = int'(frogger_pkg::CAR_W);
    localparam int CH      = int'(frogger_pkg::CAR_H);
    localparam int CSTEP   = int'(frogger_pkg::CAR_STEP);
    localparam int XT      = int'(frogger_pkg::X_TOL);
    localparam int YT      = int'(frogger_pkg::Y_TOL);
    localparam int START_X = int'(frogger_pkg::FROG_START_X);
    localparam int START_Y = int'(frogger_pkg::FROG_START_Y);
    localparam int CAR_X0  = 0;           // DUT parameter defaults
    localparam int LANE_Y  = 200;
    localparam bit DIR_R   = 1'b1;
    localparam int RAND_CYCLES = 64;

    logic                reset;           // Frame clock
    logic                frame_clk;       // Async reset
    logic                key_valid;
    frogger_pkg::key_t   key_code;
    frogger_pkg::speed_t speed;
    frogger_pkg::coord_t frog_x, frog_y, car_x, car_y;
    logic                hit;
    frogger_pkg::count_t score;
    frogger_pkg::lives_t lives;
    logic                game_over;

    row_t        stim[$];                 // Stimulus table
    int          limit_cycles = 0;        // Watchdog budget
    logic [31:0] lfsr_state = 32'haaa;
    logic [31:0] rnd;

    // Model state
    int                  m_fx, m_fy, m_cx, m_cy, m_lives, m_score;
    frogger_pkg::speed_t m_cnt;           // Frames since last car step
    logic                m_hit, m_resp, m_go;
    int                  n_hits = 0;
    logic                wrap_seen = 1'b0;

    frogger_lane_top i_frogger_lane_top (
        .reset (reset), .frame_clk (frame_clk), .key_valid (key_valid),
        .key_code (key_code), .speed (speed), .frog_x (frog_x), .frog_y (frog_y),
        .car_x (car_x), .car_y (car_y), .hit (hit), .score (score),
        .lives (lives), .game_over (game_over)
    );

    initial
    begin
        reset = 1'b0;
        forever #50 reset = ~reset;       // 100 ns frame period
    end

    // --------------------------------------------------
    // Compare tasks
    // --------------------------------------------------
    task automatic check_coord(input string what, input frogger_pkg::coord_t got,
                               input frogger_pkg::coord_t want);
        if (got !== want)
        begin
            $display("ERR %0t ns: %s is %0d, expected %0d", $time, what, got, want);
            $display("test failed");
            $fatal(1, "coordinate mismatch");
        end
    endtask

    task automatic check_count(input string what, input frogger_pkg::count_t got,
                               input frogger_pkg::count_t want);
        if (got !== want)
        begin
            $display("ERR %0t ns: %s is %0d, expected %0d", $time, what, got, want);
            $display("test failed");
            $fatal(1, "score mismatch");
        end
    endtask

    task automatic check_lives(input string what, input frogger_pkg::lives_t got,
                               input frogger_pkg::lives_t want);
        if (got !== want)
        begin
            $display("ERR %0t ns: %s is %0d, expected %0d", $time, what, got, want);
            $display("test failed");
            $fatal(1, "lives mismatch");
        end
    endtask

    task automatic check_flag(input string what, input logic got, input logic want);
        if (got !== want)
        begin
            $display("ERR %0t ns: %s is %b, expected %b", $time, what, got, want);
            $display("test failed");
            $fatal(1, "flag mismatch");
        end
    endtask

    task automatic check_all();
        check_coord("frog_x", frog_x, frogger_pkg::coord_t'(m_fx));
        check_coord("frog_y", frog_y, frogger_pkg::coord_t'(m_fy));
        check_coord("car_x", car_x, frogger_pkg::coord_t'(m_cx));
        check_coord("car_y", car_y, frogger_pkg::coord_t'(m_cy));
        check_flag("hit", hit, m_hit);
        check_count("score", score, frogger_pkg::count_t'(m_score));
        check_lives("lives", lives, frogger_pkg::lives_t'(m_lives));
        check_flag("game_over", game_over, m_go);
    endtask

    // --------------------------------------------------
    // Reference model
    // --------------------------------------------------
    function automatic logic point_in_car(input int px, input int py, input int cx, input int cy);
        return (px >= cx) && (px <= cx + CW) && (py >= cy) && (py <= cy + CH);
    endfunction

    // Shrunk frog corners against the car box with edges included
    function automatic logic frog_on_car(input int fx, input int fy, input int cx, input int cy);
        return point_in_car(fx + XT, fy + YT, cx, cy)
            || point_in_car(fx + FSIDE - XT, fy + YT, cx, cy)
            || point_in_car(fx + XT, fy + FSIDE - YT, cx, cy)
            || point_in_car(fx + FSIDE - XT, fy + FSIDE - YT, cx, cy);
    endfunction

    task automatic model_step(input logic kv, input frogger_pkg::key_t kc,
                              input frogger_pkg::speed_t spd);
        logic ov;
        logic ev_hit;
        logic ev_home;
        ov      = frog_on_car(m_fx, m_fy, m_cx, m_cy);
        ev_hit  = ov && !m_go && !m_resp;
        ev_home = (m_fy == 0) && !ov && !m_go && !m_resp;
        if (m_resp)                       // Respawn beats a key
        begin
            m_fx = START_X;
            m_fy = START_Y;
        end
        else if (kv && !m_go)
        begin
            case (kc)
                frogger_pkg::key_up:    m_fy = (m_fy - FSTEP < 0) ? 0 : m_fy - FSTEP;
                frogger_pkg::key_down:  m_fy = (m_fy + FSTEP > SCR_H - FSIDE) ?
                                               SCR_H - FSIDE : m_fy + FSTEP;
                frogger_pkg::key_left:  m_fx = (m_fx - FSTEP < 0) ? 0 : m_fx - FSTEP;
                default:                m_fx = (m_fx + FSTEP > SCR_W - FSIDE) ?
                                               SCR_W - FSIDE : m_fx + FSTEP;
            endcase
        end
        if (m_cnt == spd)                 // Step every speed+1 frames
        begin
            m_cnt = '0;
            if (DIR_R && m_cx + CSTEP > SCR_W)
            begin
                m_cx      = 0;            // Wrap to left edge
                wrap_seen = 1'b1;
            end
            else if (DIR_R)
                m_cx = m_cx + CSTEP;
            else if (m_cx < CSTEP)
            begin
                m_cx      = SCR_W;
                wrap_seen = 1'b1;
            end
            else
                m_cx = m_cx - CSTEP;
        end
        else
            m_cnt = m_cnt + 5'd1;
        m_hit  = ev_hit;
        m_resp = ev_hit || ev_home;
        if (ev_hit)
        begin
            m_lives = m_lives - 1;
            n_hits  = n_hits + 1;
            if (m_lives == 0)
                m_go = 1'b1;              // Sticky until reset
        end
        if (ev_home)
            m_score = (m_score + 1) % 256;
    endtask

    // --------------------------------------------------
    // Stimulus helpers
    // --------------------------------------------------
    task automatic add_row(input logic kv, input frogger_pkg::key_t kc,
                           input frogger_pkg::speed_t spd, input int hold);
        row_t r;
        r.kv   = kv;
        r.kc   = kc;
        r.spd  = spd;
        r.hold = hold;
        stim.push_back(r);
    endtask

    task automatic add_presses(input frogger_pkg::key_t kc, input frogger_pkg::speed_t spd,
                               input int n);
        for (int i = 0; i < n; i++)
            add_row(1'b1, kc, spd, 1);
    endtask

    // Drive on the falling edge and check on the next one
    task automatic apply_cycle(input logic kv, input frogger_pkg::key_t kc,
                               input frogger_pkg::speed_t spd);
        key_valid = kv;
        key_code  = kc;
        speed     = spd;
        model_step(kv, kc, spd);
        @(posedge reset);
        @(negedge reset);
        check_all();
    endtask

    // Fibonacci LFSR with taps 32 22 2 1 stepped once per bit taken
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++)
        begin
            lfsr_state = {lfsr_state[30:0],
                          lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0]};
            v = {v[30:0], lfsr_state[0]};
        end
        return v;
    endfunction

    initial
    begin
        wait (limit_cycles > 0);
        repeat (limit_cycles) @(posedge reset);
        $display("Watchdog: run still going after %0d clock cycles", limit_cycles);
        $display("test failed");
        $fatal(1, "watchdog expired");
    end

    // --------------------------------------------------
    // Main sequence
    // --------------------------------------------------
    initial
    begin
        frame_clk = 1'b1;
        key_valid = 1'b0;
        key_code  = frogger_pkg::key_up;
        speed     = '0;

        // Frog moves with the car slow and far away
        add_presses(frogger_pkg::key_right, 5'd31, 1);
        add_presses(frogger_pkg::key_left, 5'd31, 1);
        add_presses(frogger_pkg::key_up, 5'd31, 1);
        add_presses(frogger_pkg::key_down, 5'd31, 1);
        add_presses(frogger_pkg::key_left, 5'd31, 9);   // Ends clamped at 0
        add_presses(frogger_pkg::key_down, 5'd31, 2);   // Already at bottom
        add_presses(frogger_pkg::key_right, 5'd31, 16); // Ends clamped at 600
        // Home run at column 600
        add_presses(frogger_pkg::key_up, 5'd31, 11);
        add_row(1'b0, frogger_pkg::key_up, 5'd31, 4);
        // Car pacing and wrap
        add_row(1'b0, frogger_pkg::key_up, 5'd1, 24);
        add_row(1'b0, frogger_pkg::key_up, 5'd3, 24);
        add_row(1'b0, frogger_pkg::key_up, 5'd7, 40);
        add_row(1'b0, frogger_pkg::key_up, 5'd0, 120);
        // Three trips into the lane to wait for the car
        for (int t = 0; t < 3; t++)
        begin
            add_presses(frogger_pkg::key_up, 5'd0, 6);
            add_row(1'b0, frogger_pkg::key_up, 5'd0, 100);
        end
        // Keys during game over
        add_presses(frogger_pkg::key_up, 5'd0, 1);
        add_presses(frogger_pkg::key_left, 5'd0, 1);
        add_presses(frogger_pkg::key_right, 5'd0, 1);
        add_presses(frogger_pkg::key_down, 5'd0, 1);
        add_row(1'b0, frogger_pkg::key_up, 5'd0, 4);

        foreach (stim[i])
            limit_cycles += stim[i].hold;
        limit_cycles += 3 + RAND_CYCLES + 50;           // Reset, random phase, slack

        repeat (3) @(posedge reset);
        @(negedge reset);
        frame_clk = 1'b0;
        check_coord("reset frog_x", frog_x, 11'd300);
        check_coord("reset frog_y", frog_y, 11'd440);
        check_coord("reset car_x", car_x, 11'd0);
        check_coord("reset car_y", car_y, 11'd200);
        check_lives("reset lives", lives, 2'd3);
        check_count("reset score", score, 8'd0);
        check_flag("reset hit", hit, 1'b0);
        check_flag("reset game_over", game_over, 1'b0);

        m_fx    = START_X;
        m_fy    = START_Y;
        m_cx    = CAR_X0;
        m_cy    = LANE_Y;
        m_cnt   = '0;
        m_lives = 3;
        m_score = 0;
        m_hit   = 1'b0;
        m_resp  = 1'b0;
        m_go    = 1'b0;

        foreach (stim[i])
        begin
            for (int c = 0; c < stim[i].hold; c++)
                apply_cycle(stim[i].kv && (c == 0), stim[i].kc, stim[i].spd);
        end
        check_flag("game_over after table", game_over, 1'b1);
        check_coord("frozen frog_x", frog_x, 11'd300);
        check_coord("frozen frog_y", frog_y, 11'd440);

        // Random keys and speeds
        for (int n = 0; n < RAND_CYCLES; n++)
        begin
            logic                kv;
            frogger_pkg::key_t   kc;
            frogger_pkg::speed_t spd;
            rnd = rand_bits(1);
            kv  = rnd[0];
            rnd = rand_bits(2);
            kc  = frogger_pkg::key_t'(rnd[1:0]);
            rnd = rand_bits(5);
            spd = rnd[4:0];
            apply_cycle(kv, kc, spd);
        end

        if (n_hits != 3 || m_score != 1 || !wrap_seen || !m_go)
        begin
            $display("Run missed a scenario: hits %0d, score %0d, wrap %b, game over %b",
                     n_hits, m_score, wrap_seen, m_go);
            $display("test failed");
            $fatal(1, "scenario coverage incomplete");
        end
        else
        begin
            $display("test passed");
            $finish;
        end
    end

endmodule
